//--- tb_mam_dbg_top.f
mam_dbg_pkg.sv
mam_wb_adapter.sv
mam_wb_master.sv
wb_sram.sv
mam_dbg_top.sv
tb_mam_dbg_top.sv

//--- tb_mam_dbg_top.sv
// Table entries must address words 0 to 15 or out of range, since only those words are prefilled
`timescale 1ns/1ps
`default_nettype none

module tb_mam_dbg_top
  import mam_dbg_pkg::*;
();

  localparam int WAIT_LIMIT = 100;
  localparam int N_MAX      = 32;
  // Port codes for the table
  // Race and hold drive the CPU and the MAM together
  localparam int P_CPU  = 0;
  localparam int P_MAM  = 1;
  localparam int P_RACE = 2;
  localparam int P_HOLD = 3;
  // Hold count that asks for a random stall of 1 to 8 cycles
  localparam int HOLD_RND = -1;

  logic     clk;
  logic     rst;
  wb_req_t  cpu_req;
  wb_rsp_t  cpu_rsp;
  logic     cmd_valid;
  logic     cmd_ready;
  mam_cmd_t cmd;
  logic     rsp_valid;
  logic     rsp_ready;
  mam_rsp_t rsp;

  // Stimulus table
  string         t_name [N_MAX];
  int            t_port [N_MAX];
  logic          t_we   [N_MAX];
  logic [AW-1:0] t_adr  [N_MAX];
  logic [DW-1:0] t_dat  [N_MAX];
  logic [SW-1:0] t_sel  [N_MAX];
  int            t_hold [N_MAX];
  int            n_entries;

  // Shadow of the shared memory
  logic [DW-1:0] shadow [MEM_WORDS];
  int            err_count;
  int            timeout_count;
  int unsigned   seed_val;
  logic [31:0]   rnd_first;

  mam_dbg_top uut (
    .wb_in_clk_i     (clk),
    .wb_in_rst_i     (rst),
    .wb_in_req_i     (cpu_req),
    .wb_in_rsp_o     (cpu_rsp),
    .mam_cmd_valid_i (cmd_valid),
    .mam_cmd_ready_o (cmd_ready),
    .mam_cmd_i       (cmd),
    .mam_rsp_valid_o (rsp_valid),
    .mam_rsp_ready_i (rsp_ready),
    .mam_rsp_o       (rsp)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Shadow memory model
  ////////////////////////////////////////

  // Word index counts all upper address bits
  function automatic logic word_ok(input logic [AW-1:0] adr);
    return (adr >> BYTE_AW) < MEM_WORDS;
  endfunction

  // Out-of-range words read as zero
  function automatic logic [DW-1:0] shadow_read(input logic [AW-1:0] adr);
    if (!word_ok(adr)) begin
      return '0;
    end
    return shadow[adr[BYTE_AW +: MEM_AW]];
  endfunction

  task automatic shadow_write(input logic [AW-1:0] adr, input logic [DW-1:0] dat,
                              input logic [SW-1:0] sel);
    if (word_ok(adr)) begin
      for (int i = 0; i < SW; i++) begin
        if (sel[i]) begin
          shadow[adr[BYTE_AW +: MEM_AW]][8*i +: 8] = dat[8*i +: 8];
        end
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      err_count++;
    end
  endtask

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////

  // One classic transfer that leaves cyc high when keep is set
  task automatic cpu_transfer(input string name, input logic we, input logic [AW-1:0] adr,
                              input logic [DW-1:0] dat, input logic [SW-1:0] sel,
                              input logic keep, output logic [DW-1:0] rdat,
                              output logic rerr, output time t_end);
    int n;
    n    = 0;
    rdat = '0;
    rerr = 1'b0;
    @(posedge clk);
    cpu_req.adr <= adr;
    cpu_req.dat <= dat;
    cpu_req.sel <= sel;
    cpu_req.we  <= we;
    cpu_req.cyc <= 1'b1;
    cpu_req.stb <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!(cpu_rsp.ack || cpu_rsp.err) && n < WAIT_LIMIT);
    if (cpu_rsp.ack || cpu_rsp.err) begin
      rdat = cpu_rsp.dat;
      rerr = cpu_rsp.err;
    end else begin
      $display("Timeout: the CPU transfer of %s got no ack or err", name);
      timeout_count++;
    end
    t_end = $time;
    // Drop stb on the edge that ends the transfer
    @(posedge clk);
    cpu_req.stb <= 1'b0;
    cpu_req.cyc <= keep;
  endtask

  task automatic mam_command(input string name, input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] dat, input logic [SW-1:0] sel);
    int n;
    n = 0;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd.we    <= we;
    cmd.adr   <= adr;
    cmd.dat   <= dat;
    cmd.sel   <= sel;
    do begin
      @(negedge clk);
      n++;
    end while (!cmd_ready && n < WAIT_LIMIT);
    if (!cmd_ready) begin
      $display("Timeout: the MAM never took the command of %s", name);
      timeout_count++;
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  // Stalls the host for hold cycles and checks the response stays put
  task automatic mam_response(input string name, input int hold, output logic [DW-1:0] rdat,
                              output logic rerr, output time t_valid);
    int       n;
    mam_rsp_t held;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rsp_valid && n < WAIT_LIMIT);
    if (!rsp_valid) begin
      $display("Timeout: no MAM response arrived for %s", name);
      timeout_count++;
    end
    held    = rsp;
    t_valid = $time;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      compare_value({name, " valid held"}, 1, rsp_valid);
      compare_value({name, " data held"}, held.dat, rsp.dat);
      compare_value({name, " err held"}, held.err, rsp.err);
      compare_value({name, " cmd_ready low"}, 0, cmd_ready);
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;
    rdat = held.dat;
    rerr = held.err;
  endtask

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  task automatic add_entry(input string name, input int port, input logic we,
                           input logic [AW-1:0] adr, input logic [DW-1:0] dat,
                           input logic [SW-1:0] sel, input int hold);
    t_name[n_entries] = name;
    t_port[n_entries] = port;
    t_we[n_entries]   = we;
    t_adr[n_entries]  = adr;
    t_dat[n_entries]  = dat;
    t_sel[n_entries]  = sel;
    t_hold[n_entries] = hold;
    n_entries++;
  endtask

  task automatic run_entry(input int idx);
    string         name;
    logic [DW-1:0] rdat;
    logic [DW-1:0] rdat2;
    logic [DW-1:0] d_dat;
    logic [DW-1:0] exp_dat;
    logic          rerr;
    logic          rerr2;
    logic          d_err;
    time           t_a;
    time           t_b;
    time           d_t;
    int            hold;
    name    = t_name[idx];
    hold    = (t_hold[idx] == HOLD_RND) ? 1 + ($urandom % 8) : t_hold[idx];
    exp_dat = shadow_read(t_adr[idx]);
    case (t_port[idx])
      P_CPU, P_MAM: begin
        if (t_port[idx] == P_CPU) begin
          cpu_transfer(name, t_we[idx], t_adr[idx], t_dat[idx], t_sel[idx], 1'b0,
                       rdat, rerr, t_a);
        end else begin
          mam_command(name, t_we[idx], t_adr[idx], t_dat[idx], t_sel[idx]);
          mam_response(name, hold, rdat, rerr, t_a);
        end
        compare_value({name, " err"}, !word_ok(t_adr[idx]), rerr);
        if (t_we[idx]) begin
          shadow_write(t_adr[idx], t_dat[idx], t_sel[idx]);
        end else begin
          compare_value({name, " data"}, exp_dat, rdat);
        end
      end
      P_RACE: begin
        // MAM writes while the CPU reads the same word and must see the new value
        shadow_write(t_adr[idx], t_dat[idx], t_sel[idx]);
        exp_dat = shadow_read(t_adr[idx]);
        fork
          begin
            mam_command(name, 1'b1, t_adr[idx], t_dat[idx], t_sel[idx]);
            mam_response(name, 0, rdat2, rerr2, t_b);
          end
          begin
            // One edge later so both cyc lines rise together
            @(posedge clk);
            cpu_transfer(name, 1'b0, t_adr[idx], '0, '1, 1'b0, rdat, rerr, t_a);
          end
        join
        compare_value({name, " MAM first"}, 1, t_b < t_a);
        compare_value({name, " MAM err"}, 0, rerr2);
        compare_value({name, " CPU err"}, 0, rerr);
        compare_value({name, " CPU data"}, exp_dat, rdat);
      end
      default: begin
        // CPU owns the bus over a write and a read while the MAM reads behind it
        shadow_write(t_adr[idx], t_dat[idx], t_sel[idx]);
        exp_dat = shadow_read(t_adr[idx]);
        fork
          begin
            cpu_transfer(name, 1'b1, t_adr[idx], t_dat[idx], t_sel[idx], 1'b1,
                         d_dat, d_err, d_t);
            cpu_transfer(name, 1'b0, t_adr[idx], '0, '1, 1'b0, rdat, rerr, t_a);
          end
          begin
            repeat (2) @(posedge clk);
            mam_command(name, 1'b0, t_adr[idx], '0, '1);
            mam_response(name, 0, rdat2, rerr2, t_b);
          end
        join
        compare_value({name, " CPU first"}, 1, t_a < t_b);
        compare_value({name, " CPU write err"}, 0, d_err);
        compare_value({name, " CPU err"}, 0, rerr);
        compare_value({name, " MAM err"}, 0, rerr2);
        compare_value({name, " CPU data"}, exp_dat, rdat);
        compare_value({name, " MAM data"}, exp_dat, rdat2);
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [DW-1:0] rd;
    logic [DW-1:0] rd_old;
    logic          re;
    time           t;
    seed_val      = 32'h4684da5d;
    rnd_first     = $urandom(seed_val);
    clk           = 1'b0;
    rst           = 1'b1;
    cpu_req       = '0;
    cmd_valid     = 1'b0;
    cmd           = '0;
    rsp_ready     = 1'b0;
    err_count     = 0;
    timeout_count = 0;
    n_entries     = 0;
    add_entry("cpu_wr_full",  P_CPU,  1'b1, 32'h0000_0010, 32'hA5A5_1234, 4'hF, 0);
    add_entry("cpu_rd_full",  P_CPU,  1'b0, 32'h0000_0010, 32'h0,         4'hF, 0);
    add_entry("cpu_wr_lane1", P_CPU,  1'b1, 32'h0000_0014, 32'h1122_3344, 4'h2, 0);
    add_entry("cpu_wr_upper", P_CPU,  1'b1, 32'h0000_0014, 32'hDEAD_BEEF, 4'hC, 0);
    add_entry("cpu_rd_part",  P_CPU,  1'b0, 32'h0000_0014, 32'h0,         4'hF, 0);
    add_entry("mam_wr_full",  P_MAM,  1'b1, 32'h0000_0020, 32'hCAFE_F00D, 4'hF, 0);
    add_entry("cpu_rd_mam",   P_CPU,  1'b0, 32'h0000_0020, 32'h0,         4'hF, 0);
    add_entry("cpu_wr_odd",   P_CPU,  1'b1, 32'h0000_0024, 32'h0BAD_C0DE, 4'h5, 0);
    add_entry("mam_rd_cpu",   P_MAM,  1'b0, 32'h0000_0024, 32'h0,         4'hF, 0);
    add_entry("mam_wr_ends",  P_MAM,  1'b1, 32'h0000_0028, 32'h8765_4321, 4'h9, 0);
    add_entry("mam_rd_ends",  P_MAM,  1'b0, 32'h0000_0028, 32'h0,         4'hF, 0);
    add_entry("cpu_err_wr",   P_CPU,  1'b1, 32'h0000_0400, 32'hFFFF_FFFF, 4'hF, 0);
    add_entry("cpu_err_rd",   P_CPU,  1'b0, 32'h0000_0400, 32'h0,         4'hF, 0);
    add_entry("mam_err_rd",   P_MAM,  1'b0, 32'h8000_0010, 32'h0,         4'hF, 0);
    add_entry("mam_err_wr",   P_MAM,  1'b1, 32'h8000_0010, 32'h5555_5555, 4'hF, 0);
    add_entry("cpu_rd_alias", P_CPU,  1'b0, 32'h0000_0010, 32'h0,         4'hF, 0);
    add_entry("cpu_rd_word0", P_CPU,  1'b0, 32'h0000_0000, 32'h0,         4'hF, 0);
    add_entry("race_idle",    P_RACE, 1'b1, 32'h0000_0030, 32'h1357_9BDF, 4'hF, 0);
    add_entry("cpu_holds",    P_HOLD, 1'b1, 32'h0000_0034, 32'h2468_ACE0, 4'hF, 0);
    add_entry("bp_rd",        P_MAM,  1'b0, 32'h0000_0030, 32'h0,         4'hF, HOLD_RND);
    add_entry("bp_wr",        P_MAM,  1'b1, 32'h0000_0038, 32'h7777_0000, 4'hC, HOLD_RND);
    add_entry("bp_rd_back",   P_MAM,  1'b0, 32'h0000_0038, 32'h0,         4'hF, HOLD_RND);

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_value("reset ack", 0, cpu_rsp.ack);
    compare_value("reset err", 0, cpu_rsp.err);
    compare_value("reset rty", 0, cpu_rsp.rty);
    compare_value("reset rsp_valid", 0, rsp_valid);
    compare_value("reset cmd_ready", 1, cmd_ready);

    // Random contents for words 0 to 15
    for (int w = 0; w < 16; w++) begin
      rd = $urandom;
      cpu_transfer("fill", 1'b1, AW'(w * 4), rd, '1, 1'b0, rd_old, re, t);
      compare_value("fill err", 0, re);
      shadow_write(AW'(w * 4), rd, '1);
    end

    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
      // Let the arbiter fall back to idle
      repeat (2) @(posedge clk);
    end

    $display("Done: %0d value mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mam_dbg_top.sv
// Assumes one clock; a CPU holding cyc stalls debug access, and debug latency is six cycles at best
`timescale 1ns/1ps
`default_nettype none

module mam_dbg_top
  import mam_dbg_pkg::*;
(
  input  logic     wb_in_clk_i,
  input  logic     wb_in_rst_i,
  // CPU Wishbone slave port
  input  wb_req_t  wb_in_req_i,
  output wb_rsp_t  wb_in_rsp_o,
  // Debug command channel
  input  logic     mam_cmd_valid_i,
  output logic     mam_cmd_ready_o,
  input  mam_cmd_t mam_cmd_i,
  // Debug response channel
  output logic     mam_rsp_valid_o,
  input  logic     mam_rsp_ready_i,
  output mam_rsp_t mam_rsp_o
);

  // Debug master to adapter
  wb_req_t mam_req;
  wb_rsp_t mam_rsp;
  // Adapter to memory
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;

  // Debug commands become Wishbone cycles
  mam_wb_master u_master (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .cmd_valid_i (mam_cmd_valid_i),
    .cmd_ready_o (mam_cmd_ready_o),
    .cmd_i       (mam_cmd_i),
    .rsp_valid_o (mam_rsp_valid_o),
    .rsp_ready_i (mam_rsp_ready_i),
    .rsp_o       (mam_rsp_o),
    .wb_req_o    (mam_req),
    .wb_rsp_i    (mam_rsp)
  );

  // Shares the memory between CPU and debug master
  mam_wb_adapter u_adapter (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .cpu_req_i   (wb_in_req_i),
    .cpu_rsp_o   (wb_in_rsp_o),
    .mam_req_i   (mam_req),
    .mam_rsp_o   (mam_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  // Shared on-chip memory
  wb_sram u_sram (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .wb_req_i    (mem_req),
    .wb_rsp_o    (mem_rsp)
  );

endmodule

`default_nettype wire

//--- wb_sram.sv
// Assumes classic single transfers only; cti and bte are ignored and rty is never raised
`timescale 1ns/1ps
`default_nettype none

module wb_sram
  import mam_dbg_pkg::*;
(
  input  logic    wb_in_clk_i,
  input  logic    wb_in_rst_i,
  // Wishbone slave port
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  // Storage, one entry per word
  logic [DW-1:0]     mem [MEM_WORDS];
  // Word index taken from the byte address
  logic [MEM_AW-1:0] idx;
  // Word lies inside the array
  logic              in_range;
  // New strobe with no answer outstanding
  logic              start;
  // Registered termination
  logic              ack_q;
  logic              err_q;
  // Registered read data
  logic [DW-1:0]     dat_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign idx      = wb_req_i.adr[BYTE_AW +: MEM_AW];
  // Upper address bits count too, so aliases err
  assign in_range = wb_req_i.adr[AW-1:BYTE_AW] < WORD_AW'(MEM_WORDS);
  // The answer cycle itself never starts another transfer
  assign start    = wb_req_i.cyc & wb_req_i.stb & ~(ack_q | err_q);

  ////////////////////////////////////////
  // Termination and data path
  ////////////////////////////////////////

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      // One-cycle pulse after the strobe
      ack_q <= start & in_range;
      err_q <= start & ~in_range;
    end
  end

  always_ff @(posedge wb_in_clk_i) begin
    if (start) begin
      // Old word on a write, zero outside the array
      dat_q <= in_range ? mem[idx] : '0;
    end
    if (start & in_range & wb_req_i.we) begin
      // Only selected byte lanes change
      for (int i = 0; i < SW; i++) begin
        if (wb_req_i.sel[i]) begin
          mem[idx][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    wb_rsp_o.dat = dat_q;
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = err_q;
    wb_rsp_o.rty = 1'b0;
  end

endmodule

`default_nettype wire

//--- mam_wb_master.sv
// Assumes one command in flight and classic single Wishbone cycles; rty ends a cycle as an error
`timescale 1ns/1ps
`default_nettype none

module mam_wb_master
  import mam_dbg_pkg::*;
(
  input  logic     wb_in_clk_i,
  input  logic     wb_in_rst_i,
  // Debug command channel
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  mam_cmd_t cmd_i,
  // Debug response channel
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output mam_rsp_t rsp_o,
  // Wishbone master port toward the adapter
  output wb_req_t  wb_req_o,
  input  wb_rsp_t  wb_rsp_i
);

  // Sequencer state and its next value
  logic [1:0] state_q;
  logic [1:0] state_d;
  // Command handshake fires
  logic       cmd_take;
  // Slave terminated the bus cycle
  logic       bus_done;
  // Command held for the bus cycle
  mam_cmd_t   cmd_q;
  // Response held until the host takes it
  mam_rsp_t   rsp_q;

  assign cmd_ready_o = (state_q == MST_IDLE);
  assign cmd_take    = cmd_valid_i & cmd_ready_o;
  assign bus_done    = (state_q == MST_BUS) & (wb_rsp_i.ack | wb_rsp_i.err | wb_rsp_i.rty);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MST_IDLE: begin
        if (cmd_take) begin
          state_d = MST_BUS;
        end
      end
      MST_BUS: begin
        // Hold cyc and stb until the slave answers
        if (bus_done) begin
          state_d = MST_RESP;
        end
      end
      MST_RESP: begin
        if (rsp_ready_i) begin
          state_d = MST_IDLE;
        end
      end
      default: begin
        state_d = MST_IDLE;
      end
    endcase
  end

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      state_q <= MST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload registers
  always_ff @(posedge wb_in_clk_i) begin
    if (cmd_take) begin
      cmd_q <= cmd_i;
    end
    if (bus_done) begin
      // Writes and failed cycles return zero data
      rsp_q.dat <= (cmd_q.we | ~wb_rsp_i.ack) ? '0 : wb_rsp_i.dat;
      rsp_q.err <= wb_rsp_i.err | wb_rsp_i.rty;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign rsp_valid_o = (state_q == MST_RESP);
  assign rsp_o       = rsp_q;

  always_comb begin
    wb_req_o.adr = cmd_q.adr;
    wb_req_o.dat = cmd_q.dat;
    wb_req_o.sel = cmd_q.sel;
    wb_req_o.we  = cmd_q.we;
    // Single transfer per cycle
    wb_req_o.cyc = (state_q == MST_BUS);
    wb_req_o.stb = (state_q == MST_BUS);
    wb_req_o.cti = CTI_CLASSIC;
    wb_req_o.bte = BTE_LINEAR;
  end

endmodule

`default_nettype wire

//--- mam_wb_adapter.sv
// Assumes one clock; the MAM wins from idle and a CPU that keeps cyc high stalls the MAM for good
`timescale 1ns/1ps
`default_nettype none

module mam_wb_adapter
  import mam_dbg_pkg::*;
(
  input  logic    wb_in_clk_i,
  input  logic    wb_in_rst_i,
  // CPU master side
  input  wb_req_t cpu_req_i,
  output wb_rsp_t cpu_rsp_o,
  // Debug master side
  input  wb_req_t mam_req_i,
  output wb_rsp_t mam_rsp_o,
  // Toward the shared memory
  output wb_req_t mem_req_o,
  input  wb_rsp_t mem_rsp_i
);

  // Arbiter state and its next value
  logic [1:0] arb_q;
  logic [1:0] arb_d;
  // Raised while a master holds the arbiter
  logic       grant_cpu;
  logic       grant_mam;
  // Registered owner, high picks the CPU
  logic       access_cpu_q;
  // Owner flag has caught up with a grant
  logic       owned_q;
  // Owner and arbiter state agree
  logic       route_ok;
  // Owner request before the cycle gate
  wb_req_t    sel_req;

  ////////////////////////////////////////
  // Arbiter FSM
  ////////////////////////////////////////

  always_comb begin
    grant_cpu = 1'b0;
    grant_mam = 1'b0;
    arb_d     = ARB_IDLE;
    case (arb_q)
      ARB_IDLE: begin
        // Debug access goes first when both ask together
        if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end else if (cpu_req_i.cyc) begin
          arb_d = ARB_CPU;
        end
      end
      ARB_MAM: begin
        grant_mam = 1'b1;
        if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end
      end
      ARB_CPU: begin
        grant_cpu = 1'b1;
        // CPU finishes its whole cycle before a handover
        if (cpu_req_i.cyc) begin
          arb_d = ARB_CPU;
        end else if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end
      end
      default: begin
        arb_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      arb_q        <= ARB_IDLE;
      access_cpu_q <= 1'b0;
      owned_q      <= 1'b0;
    end else begin
      arb_q   <= arb_d;
      // Owner lags the grant by one edge, two edges after the request
      owned_q <= grant_cpu | grant_mam;
      if (grant_cpu) begin
        access_cpu_q <= 1'b1;
      end else if (grant_mam) begin
        access_cpu_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Request and response steering
  ////////////////////////////////////////

  // Blocks a stale owner during a handover
  assign route_ok = owned_q & (access_cpu_q ? (arb_q == ARB_CPU) : (arb_q == ARB_MAM));

  always_comb begin
    sel_req       = access_cpu_q ? cpu_req_i : mam_req_i;
    mem_req_o     = sel_req;
    // Memory sees a cycle only once ownership has settled
    mem_req_o.cyc = sel_req.cyc & route_ok;
    mem_req_o.stb = sel_req.stb & route_ok;
  end

  // Non-owner sees an idle slave
  always_comb begin
    cpu_rsp_o = '0;
    mam_rsp_o = '0;
    if (access_cpu_q) begin
      cpu_rsp_o = mem_rsp_i;
    end else begin
      mam_rsp_o = mem_rsp_i;
    end
  end

endmodule

`default_nettype wire

//--- mam_dbg_pkg.sv
// Assumes one clock, 32-bit buses and word-aligned single transfers with no burst support
`default_nettype none

package mam_dbg_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Address and data widths shared by every Wishbone bus here
  localparam int AW = 32;
  localparam int DW = 32;
  // One select bit per byte lane
  localparam int SW = DW / 8;
  // Low address bits that pick the byte inside a word
  localparam int BYTE_AW = 2;
  // Word part of a byte address
  localparam int WORD_AW = AW - BYTE_AW;

  // Shared memory depth in words and the width of its index
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  // Cycle and burst type codes put out by the debug master
  localparam logic [2:0] CTI_CLASSIC = 3'b000;
  localparam logic [1:0] BTE_LINEAR  = 2'b00;

  // Arbiter FSM encoding
  localparam logic [1:0] ARB_IDLE = 2'd0;
  localparam logic [1:0] ARB_MAM  = 2'd1;
  localparam logic [1:0] ARB_CPU  = 2'd2;

  // Debug master sequencer encoding
  localparam logic [1:0] MST_IDLE = 2'd0;
  localparam logic [1:0] MST_BUS  = 2'd1;
  localparam logic [1:0] MST_RESP = 2'd2;

  ////////////////////////////////////////
  // Bus bundles
  ////////////////////////////////////////

  // Everything a Wishbone master drives
  typedef struct packed {
    logic [AW-1:0] adr;
    logic [DW-1:0] dat;
    logic [SW-1:0] sel;
    logic          we;
    logic          cyc;
    logic          stb;
    logic [2:0]    cti;
    logic [1:0]    bte;
  } wb_req_t;

  // Everything a Wishbone slave returns
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          ack;
    logic          err;
    logic          rty;
  } wb_rsp_t;

  // One debug command, byte address plus lane selects
  typedef struct packed {
    logic          we;
    logic [AW-1:0] adr;
    logic [DW-1:0] dat;
    logic [SW-1:0] sel;
  } mam_cmd_t;

  // One debug response
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          err;
  } mam_rsp_t;

endpackage

`default_nettype wire
